// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // basic widths
  localparam int WORD_W    = 16;
  localparam int OP_W      = 5;
  localparam int REG_IDX_W = 3;
  localparam int IMM_W     = 8;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [WORD_W-1:0]    instr_t;
  typedef logic [OP_W-1:0]      opcode_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [IMM_W-1:0]     imm_t;
  typedef logic [1:0]           bsel_t;   // alu operand b source

  // instruction field positions
  localparam int OP_LSB  = 0;
  localparam int IMM_BIT = 4;             // opcode bit, immediate form
  localparam int RX_LSB  = 5;
  localparam int RY_LSB  = 8;
  localparam int IMM_LSB = 8;             // overlaps ry

  // opcodes, register forms (immediate forms set bit 4)
  localparam opcode_t OP_MV   = 5'b0_0000;
  localparam opcode_t OP_ADD  = 5'b0_0001;
  localparam opcode_t OP_SUB  = 5'b0_0010;
  localparam opcode_t OP_CMP  = 5'b0_0011;
  localparam opcode_t OP_LD   = 5'b0_0100;
  localparam opcode_t OP_ST   = 5'b0_0101;
  localparam opcode_t OP_MVHI = 5'b1_0110;
  localparam opcode_t OP_NOP  = 5'b0_0111;

  localparam instr_t NOP = {11'd0, OP_NOP};

  // alu b mux encodings
  localparam bsel_t BSEL_FW  = 2'd0;
  localparam bsel_t BSEL_IMM = 2'd1;
  localparam bsel_t BSEL_RY  = 2'd2;

endpackage

`default_nettype wire

// File: cpu_ex_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ex_ctrl_if import cpu_pkg::*; ();

  logic  pc_wr_ld;         // ir_ex load
  logic  ir_wr_ld;         // ir_wr and carried values load
  logic  alu_r_ld;
  logic  alu_n_ld;
  logic  alu_z_ld;
  logic  alu_a_sel;        // 1: rx, 0: forwarded
  bsel_t alu_b_sel;
  logic  alu_op_sel;       // 1: subtract
  logic  datax_wr_ld;      // write-back may write rx
  logic  datay_wr_ld;      // write-back holds an instruction
  logic  datax_wr_sel;     // carried rx from forward path
  logic  datay_wr_sel;     // carried ry from forward path
  logic  ldst_rd;
  logic  ldst_wr;
  logic  ldst_addr_sel;
  logic  ldst_wrdata_sel;
  logic  advance;          // pipeline moves this edge

  modport ctrl (
    output pc_wr_ld, ir_wr_ld, alu_r_ld, alu_n_ld, alu_z_ld,
    output alu_a_sel, alu_b_sel, alu_op_sel,
    output datax_wr_ld, datay_wr_ld, datax_wr_sel, datay_wr_sel,
    output ldst_rd, ldst_wr, ldst_addr_sel, ldst_wrdata_sel,
    input  advance
  );

  modport dp (
    input  pc_wr_ld, ir_wr_ld, alu_r_ld, alu_n_ld, alu_z_ld,
    input  alu_a_sel, alu_b_sel, alu_op_sel,
    input  datax_wr_ld, datay_wr_ld, datax_wr_sel, datay_wr_sel,
    input  ldst_rd, ldst_wr, ldst_addr_sel, ldst_wrdata_sel,
    output advance
  );

endinterface

`default_nettype wire

// File: cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  reg_idx_t i_rd_a_idx,
  input  reg_idx_t i_rd_b_idx,
  output word_t    o_rd_a,
  output word_t    o_rd_b,
  input  logic     i_we,
  input  reg_idx_t i_wr_idx,
  input  word_t    i_wr_data
);

  localparam int NREGS = 2**REG_IDX_W;

  word_t regs [NREGS];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;                     // all registers start at zero
      end
    end else if (i_we) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  // write-through, so an instruction accepted in the retire cycle sees the new value
  assign o_rd_a = (i_we && (i_wr_idx == i_rd_a_idx)) ? i_wr_data : regs[i_rd_a_idx];
  assign o_rd_b = (i_we && (i_wr_idx == i_rd_b_idx)) ? i_wr_data : regs[i_rd_b_idx];

endmodule

`default_nettype wire

// File: cpu_execute_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute_control
  import cpu_pkg::*;
(
  input  instr_t      i_ir_ex,
  input  instr_t      i_ir_wr,

  input  logic        i_fw_rx,    // ir_wr writes the rx of ir_ex
  input  logic        i_fw_ry,    // ir_wr writes the ry of ir_ex

  cpu_ex_ctrl_if.ctrl ctrl
);

  opcode_t op_ex;
  opcode_t op_wr;
  logic    imm_ex;                // immediate form in execute
  logic    is_mv;
  logic    is_alu;
  logic    is_ldst;
  logic    is_mvhi;
  logic    wr_busy;

  assign op_ex  = i_ir_ex[OP_LSB +: OP_W];
  assign op_wr  = i_ir_wr[OP_LSB +: OP_W];
  assign imm_ex = op_ex[IMM_BIT];

  // class of ir_ex, bit 4 ignored
  assign is_mv   = (op_ex[3:0] == OP_MV[3:0]);
  assign is_alu  = (op_ex[3:0] == OP_ADD[3:0]) || (op_ex[3:0] == OP_SUB[3:0]) ||
                   (op_ex[3:0] == OP_CMP[3:0]);
  assign is_ldst = (op_ex[3:0] == OP_LD[3:0]) || (op_ex[3:0] == OP_ST[3:0]);
  assign is_mvhi = (op_ex[3:0] == OP_MVHI[3:0]);

  // bubble in write-back, nothing to retire or write
  assign wr_busy = (op_wr != OP_NOP);

  assign ctrl.datax_wr_ld = wr_busy;
  assign ctrl.datay_wr_ld = wr_busy;

  always_comb begin
    ctrl.pc_wr_ld        = ctrl.advance;   // both stages move together
    ctrl.ir_wr_ld        = ctrl.advance;
    ctrl.alu_r_ld        = 1'b0;
    ctrl.alu_n_ld        = 1'b0;
    ctrl.alu_z_ld        = 1'b0;
    ctrl.alu_a_sel       = 1'b1;
    ctrl.alu_b_sel       = BSEL_RY;
    ctrl.alu_op_sel      = 1'b0;
    ctrl.datax_wr_sel    = 1'b0;
    ctrl.datay_wr_sel    = 1'b0;
    ctrl.ldst_rd         = 1'b0;
    ctrl.ldst_wr         = 1'b0;
    ctrl.ldst_addr_sel   = 1'b0;
    ctrl.ldst_wrdata_sel = 1'b0;

    // mv carries ry, mvi takes its value from ir_wr later
    if (is_mv && !imm_ex) begin
      ctrl.datay_wr_sel = i_fw_ry;
    end

    // mvhi keeps the low byte of rx
    if (is_mvhi) begin
      ctrl.datax_wr_sel = i_fw_rx;
    end

    // add, sub, cmp and immediate forms
    if (is_alu) begin
      ctrl.alu_r_ld   = ctrl.advance;
      ctrl.alu_n_ld   = ctrl.advance;
      ctrl.alu_z_ld   = ctrl.advance;
      ctrl.alu_op_sel = op_ex[1];          // sub and cmp
      ctrl.alu_a_sel  = !i_fw_rx;
      if (imm_ex) begin
        ctrl.alu_b_sel = BSEL_IMM;         // ry field is immediate, ignore fw
      end else begin
        ctrl.alu_b_sel = i_fw_ry ? BSEL_FW : BSEL_RY;
      end
    end

    // memory strobes, the unit itself waits for the advancing edge
    if (is_ldst) begin
      ctrl.ldst_rd         = !op_ex[0];    // ld
      ctrl.ldst_wr         = op_ex[0];     // st
      ctrl.ldst_addr_sel   = i_fw_rx;
      ctrl.ldst_wrdata_sel = i_fw_ry;
    end
  end

endmodule

`default_nettype wire

// File: cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu
  import cpu_pkg::*;
(
  input  word_t i_a,
  input  word_t i_b,
  input  logic  i_sub,       // cmp uses this too
  output word_t o_result,
  output logic  o_n,
  output logic  o_z
);

  word_t b_eff;
  word_t sum;

  // two's complement subtract, a + ~b + 1
  assign b_eff = i_sub ? ~i_b : i_b;
  assign sum   = i_a + b_eff + {{(WORD_W-1){1'b0}}, i_sub};

  assign o_result = sum;
  assign o_n      = sum[WORD_W-1];   // sign of result
  assign o_z      = (sum == '0);

endmodule

`default_nettype wire

// File: cpu_ldst_unit.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ldst_unit
  import cpu_pkg::*;
#(
  parameter int MEM_AW = 8
)
(
  input  logic  i_clk,
  input  logic  i_advance,
  input  logic  i_rd,          // ld in execute
  input  logic  i_wr,          // st in execute
  input  logic  i_addr_sel,    // 1: address from forward path
  input  logic  i_wrdata_sel,  // 1: store data from forward path
  input  word_t i_rx,
  input  word_t i_ry,
  input  word_t i_fw_value,
  output word_t o_rddata
);

  localparam int DEPTH = 2**MEM_AW;

  word_t             mem [DEPTH];
  logic [MEM_AW-1:0] addr;
  word_t             wrdata;
  word_t             rddata;

  // low bits of rx are the address
  assign addr   = i_addr_sel ? i_fw_value[MEM_AW-1:0] : i_rx[MEM_AW-1:0];
  assign wrdata = i_wrdata_sel ? i_fw_value : i_ry;

  // single port, accessed only when the pipe moves
  always_ff @(posedge i_clk) begin
    if (i_advance && i_wr) begin
      mem[addr] <= wrdata;
    end
    if (i_advance && i_rd) begin
      rddata <= mem[addr];      // load data for write-back
    end
  end

  assign o_rddata = rddata;

endmodule

`default_nettype wire

// File: cpu_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute_stage
  import cpu_pkg::*;
#(
  parameter int MEM_AW = 8
)
(
  input  logic     i_clk,
  input  logic     i_arst_n,
  input  logic     i_valid,
  input  instr_t   i_instr,
  output logic     o_ready,
  input  word_t    i_rx_data,
  input  word_t    i_ry_data,
  cpu_ex_ctrl_if.dp ctl,
  output instr_t   o_ir_ex,
  output logic     o_fw_rx,
  output logic     o_fw_ry,
  output logic     o_wb_valid,
  output instr_t   o_wb_instr,
  output logic     o_wb_we,
  output reg_idx_t o_wb_reg,
  output word_t    o_wb_data,
  input  logic     i_wb_ready,
  output logic     o_flag_n,
  output logic     o_flag_z
);

  instr_t  ir_ex;
  instr_t  ir_wr;
  word_t   rx_ex;          // operands read at accept
  word_t   ry_ex;
  word_t   imm_ex;
  word_t   fw_value;       // write-back value of ir_wr
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_res;
  logic    alu_n;
  logic    alu_z;
  word_t   alu_r;
  word_t   datax_wr;       // rx carried for mvhi
  word_t   datay_wr;       // ry carried for mv
  word_t   ld_data;
  logic    flag_n;
  logic    flag_z;
  opcode_t op_wr;
  logic    wb_writes;
  word_t   wb_data;

  // hold only when a retiring instruction is not taken
  assign ctl.advance = !(o_wb_valid && !i_wb_ready);
  assign o_ready     = ctl.advance;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ir_ex <= NOP;
    end else if (ctl.pc_wr_ld) begin
      ir_ex <= i_valid ? i_instr : NOP;   // bubble when nothing offered
    end
  end

  always_ff @(posedge i_clk) begin
    if (ctl.pc_wr_ld) begin
      rx_ex <= i_rx_data;
      ry_ex <= i_ry_data;
    end
  end

  assign imm_ex = {{(WORD_W-IMM_W){ir_ex[IMM_LSB+IMM_W-1]}}, ir_ex[IMM_LSB +: IMM_W]};

  assign alu_a = ctl.alu_a_sel ? rx_ex : fw_value;
  always_comb begin
    case (ctl.alu_b_sel)
      BSEL_FW:  alu_b = fw_value;
      BSEL_IMM: alu_b = imm_ex;
      default:  alu_b = ry_ex;
    endcase
  end

  cpu_alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_sub    (ctl.alu_op_sel),
    .o_result (alu_res),
    .o_n      (alu_n),
    .o_z      (alu_z)
  );

  cpu_ldst_unit #(.MEM_AW(MEM_AW)) u_ldst (
    .i_clk        (i_clk),
    .i_advance    (ctl.advance),
    .i_rd         (ctl.ldst_rd),
    .i_wr         (ctl.ldst_wr),
    .i_addr_sel   (ctl.ldst_addr_sel),
    .i_wrdata_sel (ctl.ldst_wrdata_sel),
    .i_rx         (rx_ex),
    .i_ry         (ry_ex),
    .i_fw_value   (fw_value),
    .o_rddata     (ld_data)
  );

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ir_wr  <= NOP;
      flag_n <= 1'b0;
      flag_z <= 1'b0;
    end else begin
      if (ctl.ir_wr_ld) ir_wr  <= ir_ex;
      if (ctl.alu_n_ld) flag_n <= alu_n;
      if (ctl.alu_z_ld) flag_z <= alu_z;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ctl.alu_r_ld) alu_r <= alu_res;
    if (ctl.ir_wr_ld) begin
      datax_wr <= ctl.datax_wr_sel ? fw_value : rx_ex;
      datay_wr <= ctl.datay_wr_sel ? fw_value : ry_ex;
    end
  end

  // result of the retiring instruction
  assign op_wr = ir_wr[OP_LSB +: OP_W];
  always_comb begin
    wb_writes = 1'b1;
    wb_data   = alu_r;
    case (op_wr[3:0])
      OP_MV[3:0]:   wb_data = op_wr[IMM_BIT] ?
                      {{(WORD_W-IMM_W){ir_wr[IMM_LSB+IMM_W-1]}}, ir_wr[IMM_LSB +: IMM_W]} :
                      datay_wr;
      OP_ADD[3:0],
      OP_SUB[3:0]:  wb_data = alu_r;
      OP_LD[3:0]:   wb_data = ld_data;
      OP_MVHI[3:0]: wb_data = {ir_wr[IMM_LSB +: IMM_W], datax_wr[IMM_W-1:0]};
      default:      wb_writes = 1'b0;       // st, cmp, nop
    endcase
  end

  assign fw_value   = wb_data;
  assign o_wb_valid = ctl.datay_wr_ld;
  assign o_wb_we    = ctl.datax_wr_ld && wb_writes;
  assign o_wb_instr = ir_wr;
  assign o_wb_reg   = ir_wr[RX_LSB +: REG_IDX_W];   // destination is always rx
  assign o_wb_data  = wb_data;

  // raw hazard against the instruction in write-back
  assign o_fw_rx = o_wb_we && (o_wb_reg == ir_ex[RX_LSB +: REG_IDX_W]);
  assign o_fw_ry = o_wb_we && (o_wb_reg == ir_ex[RY_LSB +: REG_IDX_W]);

  assign o_ir_ex  = ir_ex;
  assign o_flag_n = flag_n;
  assign o_flag_z = flag_z;

endmodule

`default_nettype wire

// File: cpu_core_ex.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_ex
  import cpu_pkg::*;
#(
  parameter int MEM_AW = 8
)
(
  input  logic     i_clk,
  input  logic     i_arst_n,

  input  logic     i_valid,
  input  instr_t   i_instr,
  output logic     o_ready,

  output logic     o_wb_valid,
  output instr_t   o_wb_instr,
  output logic     o_wb_we,
  output reg_idx_t o_wb_reg,
  output word_t    o_wb_data,
  input  logic     i_wb_ready,

  output logic     o_flag_n,
  output logic     o_flag_z
);

  word_t  rf_rx;       // read with the incoming instruction
  word_t  rf_ry;
  instr_t ir_ex;
  logic   fw_rx;
  logic   fw_ry;
  logic   rf_we;       // write as the instruction leaves write-back

  cpu_ex_ctrl_if ex_ctrl ();

  assign rf_we = o_wb_we && o_ready;

  // write port fed straight from write-back
  cpu_regfile u_regfile (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_rd_a_idx (i_instr[RX_LSB +: REG_IDX_W]),
    .i_rd_b_idx (i_instr[RY_LSB +: REG_IDX_W]),
    .o_rd_a     (rf_rx),
    .o_rd_b     (rf_ry),
    .i_we       (rf_we),
    .i_wr_idx   (o_wb_reg),
    .i_wr_data  (o_wb_data)
  );

  cpu_execute_control u_ctrl (
    .i_ir_ex (ir_ex),
    .i_ir_wr (o_wb_instr),
    .i_fw_rx (fw_rx),
    .i_fw_ry (fw_ry),
    .ctrl    (ex_ctrl.ctrl)
  );

  cpu_execute_stage #(.MEM_AW(MEM_AW)) u_exec (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_valid    (i_valid),
    .i_instr    (i_instr),
    .o_ready    (o_ready),
    .i_rx_data  (rf_rx),
    .i_ry_data  (rf_ry),
    .ctl        (ex_ctrl.dp),
    .o_ir_ex    (ir_ex),
    .o_fw_rx    (fw_rx),
    .o_fw_ry    (fw_ry),
    .o_wb_valid (o_wb_valid),
    .o_wb_instr (o_wb_instr),
    .o_wb_we    (o_wb_we),
    .o_wb_reg   (o_wb_reg),
    .o_wb_data  (o_wb_data),
    .i_wb_ready (i_wb_ready),
    .o_flag_n   (o_flag_n),
    .o_flag_z   (o_flag_z)
  );

endmodule

`default_nettype wire

// File: cpu_core_ex_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_ex_properties (
  input wire logic        i_clk,
  input wire logic        i_arst_n,
  input wire logic        o_ready,
  input wire logic        o_wb_valid,
  input wire logic [15:0] o_wb_instr,
  input wire logic        o_wb_we,
  input wire logic [2:0]  o_wb_reg,
  input wire logic [15:0] o_wb_data,
  input wire logic        i_wb_ready
);

  int unsigned fail_cnt = 0;   // failed assertions so far

  // stalled trace port holds everything
  a_trace_stable : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_wb_valid && !i_wb_ready) |=> (o_wb_valid && $stable(o_wb_instr) &&
      $stable(o_wb_we) && $stable(o_wb_reg) && $stable(o_wb_data)))
    else begin
      $error("trace outputs changed while stalled");
      fail_cnt++;
    end

  a_ready_rule : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_ready == !(o_wb_valid && !i_wb_ready))
    else begin
      $error("o_ready does not match advance rule");
      fail_cnt++;
    end

  a_we_valid : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_wb_we |-> o_wb_valid)   // no write without a retiring instruction
    else begin
      $error("o_wb_we high without o_wb_valid");
      fail_cnt++;
    end

endmodule

bind cpu_core_ex cpu_core_ex_properties u_props (
  .i_clk(i_clk), .i_arst_n(i_arst_n), .o_ready(o_ready), .o_wb_valid(o_wb_valid),
  .o_wb_instr(o_wb_instr), .o_wb_we(o_wb_we), .o_wb_reg(o_wb_reg),
  .o_wb_data(o_wb_data), .i_wb_ready(i_wb_ready)
);

`default_nettype wire

// File: tb_cpu_core_ex.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core_ex;

  localparam int NT = 24;                      // table length
  localparam int LIMIT_NS = (NT * 8 + 20) * 100;
  localparam logic [4:0] MV = 5'h00, ADD = 5'h01, SUB = 5'h02, CMP = 5'h03;
  localparam logic [4:0] LD = 5'h04, ST = 5'h05, NOPC = 5'h07, MVHI = 5'h16;
  localparam logic [4:0] MVI = 5'h10, ADDI = 5'h11, SUBI = 5'h12, CMPI = 5'h13;
  localparam logic [15:0] NOP_W = 16'h0007;

  logic i_clk = 1'b0, i_arst_n = 1'b0, i_valid = 1'b0, i_wb_ready = 1'b0;
  logic [15:0] i_instr = NOP_W;
  logic o_ready, o_wb_valid, o_wb_we, o_flag_n, o_flag_z;
  logic [15:0] o_wb_instr, o_wb_data;
  logic [2:0] o_wb_reg;

  logic [15:0] tbl_instr [NT];                 // hand derived stimulus and results
  logic        tbl_we [NT];
  logic [2:0]  tbl_reg [NT];
  logic [15:0] tbl_data [NT];
  logic        exp_n [NT];                     // flags after each entry, from shadow model
  logic        exp_z [NT];
  int          exp_idx [NT];                   // table index of each retiring entry
  int          acc_cyc [NT];
  int          n_tbl = 0, n_exp, errors = 0;
  logic [31:0] lfsr = 32'h76ee;

  cpu_core_ex #(.MEM_AW(8)) uut (.*);

  always #50 i_clk = ~i_clk;

  initial begin
    #(LIMIT_NS * 1ns);
    $display("watchdog expired, the pipeline stopped retiring instructions");
    $display("Regression failed");
    $finish;
  end

  function automatic int take_bits(input int n);
    int r = 0;
    logic fb;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      r = (r << 1) | int'(fb);
    end
    return r;
  endfunction

  function automatic logic [15:0] enc_rr(input logic [4:0] op, input logic [2:0] rx,
                                         input logic [2:0] ry);
    return {5'b0, ry, rx, op};
  endfunction

  function automatic logic [15:0] enc_ri(input logic [4:0] op, input logic [2:0] rx,
                                         input logic [7:0] imm);
    return {imm, rx, op};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic entry(input logic [15:0] ins, input logic we, input logic [2:0] rg,
                       input logic [15:0] d);
    tbl_instr[n_tbl] = ins;
    tbl_we[n_tbl] = we;
    tbl_reg[n_tbl] = rg;
    tbl_data[n_tbl] = d;
    n_tbl++;
  endtask

  // shadow model confirms the hand table and supplies the flags
  task automatic run_model();
    logic [15:0] r [8];
    logic [15:0] m [256];
    logic [15:0] d, sx, x, y;
    logic [4:0]  op;
    logic [2:0]  rx;
    logic        we, n, z;
    n = 1'b0;
    z = 1'b0;
    n_exp = 0;
    for (int i = 0; i < 8; i++) r[i] = 16'h0;
    for (int i = 0; i < NT; i++) begin
      op = tbl_instr[i][4:0];
      rx = tbl_instr[i][7:5];
      x  = r[rx];
      y  = r[tbl_instr[i][10:8]];
      sx = {{8{tbl_instr[i][15]}}, tbl_instr[i][15:8]};
      we = 1'b1;
      d  = 16'h0;
      case (op)
        MV:        d = y;
        MVI:       d = sx;
        ADD, ADDI: d = x + ((op == ADD) ? y : sx);
        SUB, SUBI, CMP, CMPI: d = x - (op[4] ? sx : y);
        LD:        d = m[x[7:0]];
        MVHI:      d = {tbl_instr[i][15:8], x[7:0]};
        default:   we = 1'b0;                  // st and nop
      endcase
      if (op == ST) m[x[7:0]] = y;
      if (op[3:0] inside {4'h1, 4'h2, 4'h3}) begin
        n = d[15];
        z = (d == 16'h0);
      end
      if (op[3:0] == 4'h3) we = 1'b0;          // cmp only sets flags
      if (we) r[rx] = d;
      exp_n[i] = n;
      exp_z[i] = z;
      check($sformatf("table entry %0d we", i), 32'(we), 32'(tbl_we[i]));
      if (we) check($sformatf("table entry %0d data", i), 32'(d), 32'(tbl_data[i]));
      if (op != NOPC) begin
        exp_idx[n_exp] = i;
        n_exp++;
      end
    end
  endtask

  task automatic run_pass(input logic gaps);
    int idx = 0, ret = 0, cyc = 0, k;
    i_valid = 1'b0;
    i_instr = NOP_W;
    i_wb_ready = 1'b1;
    i_arst_n = 1'b0;
    repeat (4) @(posedge i_clk);
    #1 i_arst_n = 1'b1;
    @(negedge i_clk);
    check("o_wb_valid after reset", 32'(o_wb_valid), 32'd0);
    check("o_ready after reset", 32'(o_ready), 32'd1);
    while (ret < n_exp) begin
      @(posedge i_clk);
      #1;
      i_valid = (idx < NT) && (!gaps || take_bits(2) != 0);
      i_instr = i_valid ? tbl_instr[idx] : NOP_W;
      i_wb_ready = !gaps || take_bits(2) != 0;
      @(negedge i_clk);
      cyc++;
      if (o_wb_valid && i_wb_ready) begin
        k = exp_idx[ret];
        check("trace instr", 32'(o_wb_instr), 32'(tbl_instr[k]));
        check("trace we", 32'(o_wb_we), 32'(tbl_we[k]));
        check("trace reg", 32'(o_wb_reg), 32'(tbl_reg[k]));
        if (tbl_we[k]) check("trace data", 32'(o_wb_data), 32'(tbl_data[k]));
        check("flag n", 32'(o_flag_n), 32'(exp_n[k]));
        check("flag z", 32'(o_flag_z), 32'(exp_z[k]));
        if (!gaps) check("accept to trace cycles", 32'(cyc - acc_cyc[k]), 32'd2);
        ret++;
      end
      if (i_valid && o_ready) begin
        acc_cyc[idx] = cyc;
        idx++;
      end
    end
    @(posedge i_clk);
    #1;
    i_valid = 1'b0;                            // idle while the pipe drains
    i_instr = NOP_W;
    i_wb_ready = 1'b1;
    repeat (3) begin
      @(negedge i_clk);
      check("o_wb_valid after drain", 32'(o_wb_valid), 32'd0);  // nothing extra retires
    end
    @(posedge i_clk);
    #1;
  endtask

  initial begin
    entry(enc_ri(MVI, 3'd1, 8'h05), 1'b1, 3'd1, 16'h0005);
    entry(enc_ri(MVI, 3'd2, 8'hFD), 1'b1, 3'd2, 16'hFFFD);
    entry(enc_ri(MVHI, 3'd1, 8'h12), 1'b1, 3'd1, 16'h1205);
    entry(enc_rr(ADD, 3'd1, 3'd2), 1'b1, 3'd1, 16'h1202);    // rx forwarded
    entry(enc_rr(SUB, 3'd2, 3'd1), 1'b1, 3'd2, 16'hEDFB);    // ry forwarded
    entry(enc_rr(MV, 3'd3, 3'd2), 1'b1, 3'd3, 16'hEDFB);
    entry(enc_ri(ADDI, 3'd3, 8'h05), 1'b1, 3'd3, 16'hEE00);  // through mv
    entry(enc_rr(CMP, 3'd3, 3'd1), 1'b0, 3'd3, 16'h0000);
    entry(enc_ri(MVI, 3'd4, 8'h07), 1'b1, 3'd4, 16'h0007);
    entry(enc_ri(CMPI, 3'd4, 8'h07), 1'b0, 3'd4, 16'h0000);  // zero flag
    entry(enc_ri(SUBI, 3'd4, 8'h08), 1'b1, 3'd4, 16'hFFFF);
    entry(enc_ri(MVI, 3'd5, 8'h40), 1'b1, 3'd5, 16'h0040);
    entry(enc_rr(ST, 3'd5, 3'd1), 1'b0, 3'd5, 16'h0000);
    entry(enc_rr(LD, 3'd5, 3'd0), 1'b1, 3'd5, 16'h1202);     // right after the store
    entry(enc_rr(ADD, 3'd5, 3'd3), 1'b1, 3'd5, 16'h0002);    // load feeds add
    entry(enc_ri(MVI, 3'd7, 8'h80), 1'b1, 3'd7, 16'hFF80);
    entry(enc_ri(MVHI, 3'd7, 8'h7F), 1'b1, 3'd7, 16'h7F80);
    entry(enc_rr(ST, 3'd7, 3'd5), 1'b0, 3'd7, 16'h0000);
    entry(enc_rr(LD, 3'd7, 3'd0), 1'b1, 3'd7, 16'h0002);
    entry(enc_rr(SUB, 3'd6, 3'd7), 1'b1, 3'd6, 16'hFFFE);
    entry(enc_rr(SUB, 3'd7, 3'd7), 1'b1, 3'd7, 16'h0000);
    entry(NOP_W, 1'b0, 3'd0, 16'h0000);
    entry(enc_ri(ADDI, 3'd0, 8'hFF), 1'b1, 3'd0, 16'hFFFF);
    entry(enc_rr(MV, 3'd1, 3'd0), 1'b1, 3'd1, 16'hFFFF);
    run_model();
    run_pass(1'b0);   // back to back, timing checked
    run_pass(1'b1);   // random gaps and stalls
    $display("checks done, errors: %0d, assertion failures: %0d", errors,
             uut.u_props.fail_cnt);
    if (errors == 0 && uut.u_props.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_core_ex.f
cpu_pkg.sv
cpu_ex_ctrl_if.sv
cpu_regfile.sv
cpu_execute_control.sv
cpu_alu.sv
cpu_ldst_unit.sv
cpu_execute_stage.sv
cpu_core_ex.sv
cpu_core_ex_properties.sv
tb_cpu_core_ex.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_cpu_core_ex -f cpu_core_ex.f
out=$(./obj_dir/Vtb_cpu_core_ex)
echo "$out"
if echo "$out" | grep -q "Regression passed"; then
  exit 0
else
  exit 1
fi
